/* vmul_params.svh */
`ifndef VMUL_PARAMS_SVH
`define VMUL_PARAMS_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

// Operand and result width of signed Q8.8
`define VMUL_DATA_W 16

// Fraction bits of the Q8.8 format
`define VMUL_FRAC_W 8

// Job length field for up to 15 elements
`define VMUL_LEN_W 4

////////////////////////////////////////////////////////////
// Buffering
////////////////////////////////////////////////////////////

// Operand pair FIFO entries with one more than the longest job
`define VMUL_FIFO_DEPTH 16

`endif

/* vmul_pkg.sv */
package vmul_pkg;

  `include "vmul_params.svh"

  ////////////////////////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////////////////////////

  // Signed Q8.8 operand or result
  typedef logic signed [`VMUL_DATA_W-1:0] data_t;

  // Job length where zero means no job
  typedef logic [`VMUL_LEN_W-1:0] len_t;

  // Full width signed product before scaling
  typedef logic signed [2*`VMUL_DATA_W-1:0] prod_t;

  // Operand pair as queued between controller and multiplier
  typedef struct packed {
    data_t scalar;
    data_t element;
    logic  last;     // Final element of a job
  } opnd_t;

  ////////////////////////////////////////////////////////////
  // State machines
  ////////////////////////////////////////////////////////////

  // Input sequencing in the controller
  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_WAIT_SCALAR,
    CTRL_WAIT_VECTOR
  } ctrl_state_t;

  // Shift-add multiplier
  typedef enum logic [1:0] {
    MULT_IDLE,
    MULT_CALC,
    MULT_DONE
  } mult_state_t;

endpackage

/* vmul_ctrl.sv */
`timescale 1ns/10ps

module vmul_ctrl
  import vmul_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,

  // Job control
  input  logic  start,
  input  len_t  length_in,

  // Operand strobes sharing one data bus
  input  logic  scalar_in_enable,
  input  logic  vector_in_enable,
  input  data_t data_in,

  // FIFO write side
  output logic  push,
  output opnd_t push_data
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  ctrl_state_t state;

  // Latched job length and running element index
  len_t        len_q;
  len_t        idx;

  // Scalar held for the whole job
  data_t       scalar_q;

  // Current element closes the job
  logic        is_last;

  // Element strobes count only once the scalar is in
  logic        take_elem;

  assign is_last   = (idx == len_q - len_t'(1));
  assign take_elem = (state == CTRL_WAIT_VECTOR) && vector_in_enable;

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= CTRL_IDLE;
      len_q <= '0;
      idx   <= '0;
      push  <= 1'b0;
    end else begin
      // Push is a single cycle pulse per element
      push <= take_elem;

      case (state)
        CTRL_IDLE: begin
          // Zero length start is dropped
          if (start && (length_in != '0)) begin
            len_q <= length_in;
            idx   <= '0;
            state <= CTRL_WAIT_SCALAR;
          end
        end
        CTRL_WAIT_SCALAR: begin
          // Vector strobes here are stray and ignored
          if (scalar_in_enable) begin
            state <= CTRL_WAIT_VECTOR;
          end
        end
        CTRL_WAIT_VECTOR: begin
          if (vector_in_enable) begin
            idx <= idx + len_t'(1);
            // Registered push of the final pair still goes out next cycle
            if (is_last) begin
              state <= CTRL_IDLE;
            end
          end
        end
        default: begin
          state <= CTRL_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Operand capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if ((state == CTRL_WAIT_SCALAR) && scalar_in_enable) begin
      scalar_q <= data_in;
    end

    // Pair the held scalar with each new element
    if (take_elem) begin
      push_data.scalar  <= scalar_q;
      push_data.element <= data_in;
      push_data.last    <= is_last;
    end
  end

endmodule

/* vmul_fifo.sv */
`timescale 1ns/10ps

`include "vmul_params.svh"

module vmul_fifo
  import vmul_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,

  // Write side from the controller
  input  logic  push,
  input  opnd_t push_data,

  // Read side to the multiplier
  input  logic  pop,
  output logic  empty,
  output opnd_t head_data
);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // Index width of the entry array
  localparam int AW = $clog2(`VMUL_FIFO_DEPTH);

  opnd_t         mem [`VMUL_FIFO_DEPTH];

  // Pointers carry an extra wrap bit
  logic [AW:0]   wr_ptr;
  logic [AW:0]   rd_ptr;

  // Pop on an empty queue has no effect
  logic          do_pop;

  assign do_pop = pop && !empty;

  ////////////////////////////////////////////////////////////
  // Pointers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + (AW+1)'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + (AW+1)'(1);
      end
    end
  end

  // Entry array write
  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr[AW-1:0]] <= push_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Head and status
  ////////////////////////////////////////////////////////////

  // Show-ahead head, valid whenever not empty
  assign head_data = mem[rd_ptr[AW-1:0]];

  // Same index and same wrap means nothing queued
  assign empty = (wr_ptr == rd_ptr);

endmodule

/* vmul_mult.sv */
`timescale 1ns/10ps

`include "vmul_params.svh"

module vmul_mult
  import vmul_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,

  // FIFO read side
  input  logic  empty,
  input  opnd_t head_data,
  output logic  pop,

  // Product stream
  output logic  out_enable,
  output logic  ready,
  output data_t data_out
);

  ////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////

  localparam int W  = `VMUL_DATA_W;
  localparam int CW = $clog2(`VMUL_DATA_W);

  // Saturation bounds of 0x7FFF and 0x8000 after truncation
  localparam prod_t SAT_HI = (prod_t'(1) <<< (W - 1)) - prod_t'(1);
  localparam prod_t SAT_LO = -SAT_HI - prod_t'(1);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  mult_state_t   state;
  logic [CW-1:0] step;

  // Unsigned magnitudes of the popped pair
  logic [W-1:0]  scalar_mag;
  logic [W-1:0]  element_mag;

  // Shift-add datapath
  prod_t         acc;
  prod_t         mcand;
  logic [W-1:0]  mplier;
  logic          neg_q;
  logic          last_q;

  // Output stage
  prod_t         signed_prod;
  prod_t         scaled;

  // Abs value where 0x8000 maps to 32768 unsigned
  assign scalar_mag  = head_data.scalar[W-1] ? W'(-head_data.scalar) : W'(head_data.scalar);
  assign element_mag = head_data.element[W-1] ? W'(-head_data.element) : W'(head_data.element);

  // Take the head in the same cycle it is popped
  assign pop = (state == MULT_IDLE) && !empty;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= MULT_IDLE;
      step  <= '0;
    end else begin
      case (state)
        MULT_IDLE: begin
          if (pop) begin
            step  <= '0;
            state <= MULT_CALC;
          end
        end
        MULT_CALC: begin
          // One multiplier bit per cycle
          step <= step + CW'(1);
          if (step == CW'(W - 1)) begin
            state <= MULT_DONE;
          end
        end
        MULT_DONE: begin
          state <= MULT_IDLE;
        end
        default: begin
          state <= MULT_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (pop) begin
      acc    <= '0;
      mcand  <= {{W{1'b0}}, element_mag};
      mplier <= scalar_mag;
      // Result sign from operand signs
      neg_q  <= head_data.scalar[W-1] ^ head_data.element[W-1];
      last_q <= head_data.last;
    end else if (state == MULT_CALC) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand <<< 1;
      mplier <= mplier >> 1;
    end
  end

  // Sign, scale back to Q8.8 and clamp
  always_comb begin
    signed_prod = neg_q ? -acc : acc;
    // Arithmetic shift rounds toward negative infinity
    scaled = signed_prod >>> `VMUL_FRAC_W;
    if (scaled > SAT_HI) begin
      data_out = SAT_HI[W-1:0];
    end else if (scaled < SAT_LO) begin
      data_out = SAT_LO[W-1:0];
    end else begin
      data_out = scaled[W-1:0];
    end
  end

  // One cycle in DONE per product
  assign out_enable = (state == MULT_DONE);
  assign ready      = out_enable && last_q;

endmodule

/* vmul_top.sv */
`timescale 1ns/10ps

module vmul_top
  import vmul_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,

  // Job control
  input  logic  start,
  input  len_t  length_in,

  // Operand strobes
  input  logic  scalar_in_enable,
  input  logic  vector_in_enable,
  input  data_t data_in,

  // Product stream
  output data_t data_out,
  output logic  out_enable,
  output logic  ready
);

  ////////////////////////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////////////////////////

  // Controller to FIFO
  logic  push;
  opnd_t push_data;

  // FIFO to multiplier
  logic  pop;
  logic  empty;
  opnd_t head_data;

  ////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////

  // Producer of operand pairs
  vmul_ctrl ctrl_i (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .length_in       (length_in),
    .scalar_in_enable(scalar_in_enable),
    .vector_in_enable(vector_in_enable),
    .data_in         (data_in),
    .push            (push),
    .push_data       (push_data)
  );

  // Queue between the two sides
  vmul_fifo fifo_i (
    .CLK      (CLK),
    .RST      (RST),
    .push     (push),
    .push_data(push_data),
    .pop      (pop),
    .empty    (empty),
    .head_data(head_data)
  );

  // Consumer, one product per pair
  vmul_mult mult_i (
    .CLK       (CLK),
    .RST       (RST),
    .empty     (empty),
    .head_data (head_data),
    .pop       (pop),
    .out_enable(out_enable),
    .ready     (ready),
    .data_out  (data_out)
  );

endmodule

/* tb_vmul.sv */
`timescale 1ns/10ps

`include "vmul_params.svh"

module tb_vmul
  import vmul_pkg::*;
();

  // Random jobs plus five directed ones
  localparam int NUM_RAND = 20;
  localparam int NUM_JOBS = NUM_RAND + 5;
  localparam int LIMIT    = NUM_JOBS * 15 * 20 + 200;

  logic  CLK;
  logic  RST;
  logic  start;
  len_t  length_in;
  logic  scalar_in_enable;
  logic  vector_in_enable;
  data_t data_in;
  data_t data_out;
  logic  out_enable;
  logic  ready;

  // Model queues of products in element order with last flags
  data_t       exp_data[$];
  logic        exp_last[$];
  int          job_cnt = 0;
  int          ready_cnt = 0;
  int          cyc_cnt = 0;
  logic [31:0] lfsr_state = 32'hf042_3873;

  vmul_top dut_i (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Full product with floor shift by 8 and clamp to 16 bits
  function automatic data_t model_product(input data_t a, input data_t b);
    prod_t full;
    full = (prod_t'(a) * prod_t'(b)) >>> `VMUL_FRAC_W;
    if (full > 32'sd32767) return 16'h7fff;
    else if (full < -32'sd32768) return 16'h8000;
    return full[15:0];
  endfunction

  // Operands near the range limits and tiny odd ones
  function automatic data_t edge_val(input logic [2:0] idx);
    case (idx)
      3'd0: return 16'h7fff;
      3'd1: return 16'h8000;
      3'd2: return 16'h7f00;
      3'd3: return 16'h8001;
      3'd4: return 16'h0c00;
      3'd5: return 16'hf400;
      3'd6: return 16'h0001;
      default: return 16'hffff;
    endcase
  endfunction

  task automatic abort_run(input string msg);
    $display("Error at %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got=%h expected=%h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got=%b expected=%b", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("[FAIL] t=%0t %s got=%0d expected=%0d", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // All inputs for one clock cycle
  task automatic drive_cycle(input logic st, input len_t len, input logic sc,
                             input logic ve, input data_t d);
    @(posedge CLK);
    start            <= st;
    length_in        <= len;
    scalar_in_enable <= sc;
    vector_in_enable <= ve;
    data_in          <= d;
  endtask

  task automatic idle(input int n);
    repeat (n) drive_cycle(1'b0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic expect_elem(input data_t s, input data_t e, input logic last);
    exp_data.push_back(model_product(s, e));
    exp_last.push_back(last);
  endtask

  // Until every queued product has come out
  task automatic wait_done();
    while (exp_data.size() != 0) @(negedge CLK);
  endtask

  // One job where zero gap_bits gives back to back strobes
  task automatic run_job(input len_t n, input data_t s, input int gap_bits, input logic edges);
    data_t e;
    drive_cycle(1'b1, n, 1'b0, 1'b0, '0);
    job_cnt++;
    idle(int'(rand_bits(gap_bits)));
    drive_cycle(1'b0, '0, 1'b1, 1'b0, s);
    for (int i = 0; i < int'(n); i++) begin
      idle(int'(rand_bits(gap_bits)));
      e = edges ? edge_val(3'(i)) : data_t'(rand_bits(16));
      expect_elem(s, e, i == int'(n) - 1);
      drive_cycle(1'b0, '0, 1'b0, 1'b1, e);
    end
    idle(1);
    wait_done();
  endtask

  // Edges from strobe to out_enable with one element in flight
  task automatic measure_latency();
    int lat;
    lat = 0;
    drive_cycle(1'b1, 4'd1, 1'b0, 1'b0, '0);
    job_cnt++;
    drive_cycle(1'b0, '0, 1'b1, 1'b0, 16'h0180);
    expect_elem(16'h0180, 16'hfe40, 1'b1);
    drive_cycle(1'b0, '0, 1'b0, 1'b1, 16'hfe40);
    while (!out_enable) begin
      idle(1);
      lat++;
      @(negedge CLK);
    end
    check_count("out_enable latency", lat, 19);
    wait_done();
  endtask

  // Strobes outside a job and then a real job of two
  task automatic stray_strobes();
    drive_cycle(1'b0, '0, 1'b1, 1'b0, 16'h1234);
    drive_cycle(1'b1, 4'd0, 1'b0, 1'b0, '0);
    idle(2);
    drive_cycle(1'b1, 4'd2, 1'b0, 1'b0, '0);
    job_cnt++;
    drive_cycle(1'b0, '0, 1'b0, 1'b1, 16'h0200);
    drive_cycle(1'b0, '0, 1'b0, 1'b1, 16'h0300);
    // Any out_enable here hits an empty model queue
    idle(25);
    drive_cycle(1'b0, '0, 1'b1, 1'b0, 16'hff80);
    expect_elem(16'hff80, 16'h0500, 1'b0);
    drive_cycle(1'b0, '0, 1'b0, 1'b1, 16'h0500);
    expect_elem(16'hff80, 16'h0003, 1'b1);
    drive_cycle(1'b0, '0, 1'b0, 1'b1, 16'h0003);
    idle(1);
    wait_done();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    RST              = 1'b1;
    start            = 1'b0;
    length_in        = '0;
    scalar_in_enable = 1'b0;
    vector_in_enable = 1'b0;
    data_in          = '0;
    repeat (4) @(posedge CLK);
    RST <= 1'b0;
    idle(2);
    stray_strobes();
    measure_latency();
    // Full length back to back job filling the FIFO
    run_job(4'd15, data_t'(rand_bits(16)), 0, 1'b0);
    run_job(4'd8, 16'h7fff, 0, 1'b1);
    run_job(4'd8, 16'h8000, 1, 1'b1);
    for (int j = 0; j < NUM_RAND; j++) begin
      len_t n;
      // Lengths from 1 to 15
      n = len_t'(rand_bits(4));
      if (n == '0) n = len_t'(1);
      run_job(n, data_t'(rand_bits(16)), j[0] ? 2 : 0, 1'b0);
    end
    idle(5);
    if (exp_data.size() != 0 || ready_cnt != job_cnt) begin
      $display("Run ended with %0d products missing and %0d ready pulses for %0d jobs",
               exp_data.size(), ready_cnt, job_cnt);
      $display("TEST FAILED");
      $fatal(1);
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output monitor and timeout
  ////////////////////////////////////////////////////////////

  // Sampled mid cycle away from the edge
  always @(negedge CLK) begin
    if (!RST && out_enable) begin
      if (exp_data.size() == 0) abort_run("out_enable seen with no product expected");
      check_data("data_out", data_out, exp_data.pop_front());
      check_flag("ready", ready, exp_last.pop_front());
      if (ready) ready_cnt++;
    end else if (!RST) begin
      check_flag("ready", ready, 1'b0);
    end
  end

  always @(posedge CLK) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt == LIMIT) begin
      $display("Timeout after %0d cycles, the jobs did not finish", cyc_cnt);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

endmodule

/* src.f */
+incdir+.
vmul_pkg.sv
vmul_ctrl.sv
vmul_fifo.sv
vmul_mult.sv
vmul_top.sv
tb_vmul.sv

/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= src.f
TB_TOP     ?= tb_vmul
RTL_TOP    ?= vmul_top
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only
SIM_FLAGS  ?= --binary --timing
PASS_MSG   ?= TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)
